//--- include/noise_gen_cfg.svh
`ifndef NOISE_GEN_CFG_SVH
`define NOISE_GEN_CFG_SVH

// lane count, also the width of one noise word
`define NG_LANES 16

// fibonacci shift register per lane
`define NG_LFSR_WIDTH 21
`define NG_TAP_HI 20
`define NG_TAP_LO 18

// longest burst and size of the destination table
`define NG_MAX_BURST 16

// register port address width
`define NG_ADDR_WIDTH 8

// tag carried with each sample
`define NG_DEST_WIDTH 8

`endif

//--- verilog/noise_gen_pkg.sv
`default_nettype none

`include "noise_gen_cfg.svh"

package noise_gen_pkg;

    localparam int sample_width = 32;
    localparam int burst_len_width = $clog2(`NG_MAX_BURST + 1);
    localparam int entry_width = $clog2(`NG_MAX_BURST);

    typedef enum logic [1:0] {
        okay = 2'd0,
        slverr = 2'd2
    } axil_resp_e;

    typedef enum logic {
        idle,
        working
    } burst_state_e;

    // master to slave
    typedef struct packed {
        logic awvalid;
        logic [`NG_ADDR_WIDTH-1:0] awaddr;
        logic wvalid;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        logic bready;
        logic arvalid;
        logic [`NG_ADDR_WIDTH-1:0] araddr;
        logic rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        axil_resp_e bresp;
        logic arready;
        logic rvalid;
        logic [31:0] rdata;
        axil_resp_e rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [burst_len_width-1:0] burst_length;
        logic [`NG_MAX_BURST-1:0][`NG_DEST_WIDTH-1:0] dest_table;
    } noise_cfg_t;

    typedef struct packed {
        logic [sample_width-1:0] data;
        logic [`NG_DEST_WIDTH-1:0] dest;
        logic last;
    } noise_sample_t;

    // start states, lane 15 listed first
    localparam logic [`NG_LANES-1:0][`NG_LFSR_WIDTH-1:0] lane_seeds = '{
        21'h0C0FFE, 21'h16789A, 21'h034567, 21'h1EF012,
        21'h09ABCD, 21'h177889, 21'h044556, 21'h112233,
        21'h0FEDCB, 21'h154321, 21'h0ABCDE, 21'h1D2E3F,
        21'h02468A, 21'h13579B, 21'h0F3C21, 21'h1A6157
    };

endpackage

`default_nettype wire

//--- verilog/noise_regs.sv
`default_nettype none

`include "noise_gen_cfg.svh"

module noise_regs
    import noise_gen_pkg::*;
(
    input logic clock,
    input logic reset,
    input axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output noise_cfg_t cfg
);

    localparam int idx_width = `NG_ADDR_WIDTH - 2;

    logic wr_ready;
    logic rd_ready;
    logic b_valid;
    logic r_valid;
    axil_resp_e b_resp;
    axil_resp_e r_resp;
    logic [31:0] r_data;

    logic wr_take;
    logic rd_take;
    logic wr_fire;
    logic rd_fire;

    logic wr_hit;
    logic rd_hit;
    logic [idx_width-1:0] wr_index;
    logic [idx_width-1:0] rd_index;
    logic [idx_width-1:0] wr_entry;
    logic [idx_width-1:0] rd_entry;
    logic [31:0] wr_old;
    logic [31:0] wr_merged;
    logic [31:0] rd_word;

    function automatic logic addr_hit(input logic [`NG_ADDR_WIDTH-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr[`NG_ADDR_WIDTH-1:2] <= `NG_MAX_BURST);
    endfunction

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0] strb
    );
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // both write channels must be present, one response in flight per direction
    assign wr_take = axil_req.awvalid && axil_req.wvalid && !wr_ready && !b_valid;
    assign rd_take = axil_req.arvalid && !rd_ready && !r_valid;
    assign wr_fire = wr_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = rd_ready && axil_req.arvalid;

    // word index 0 is the length, 1..16 the table
    assign wr_hit = addr_hit(axil_req.awaddr);
    assign rd_hit = addr_hit(axil_req.araddr);
    assign wr_index = axil_req.awaddr[`NG_ADDR_WIDTH-1:2];
    assign rd_index = axil_req.araddr[`NG_ADDR_WIDTH-1:2];
    assign wr_entry = wr_index - 1'b1;
    assign rd_entry = rd_index - 1'b1;

    always_comb begin
        if (wr_index == '0) begin
            wr_old = 32'(cfg.burst_length);
        end else begin
            wr_old = 32'(cfg.dest_table[wr_entry[entry_width-1:0]]);
        end
        wr_merged = merge_bytes(wr_old, axil_req.wdata, axil_req.wstrb);
    end

    always_comb begin
        if (!rd_hit) begin
            rd_word = '0;
        end else if (rd_index == '0) begin
            rd_word = 32'(cfg.burst_length);
        end else begin
            rd_word = 32'(cfg.dest_table[rd_entry[entry_width-1:0]]);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ready <= 1'b0;
            rd_ready <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
            cfg <= '0;
        end else begin
            // ready is a single-cycle pulse
            wr_ready <= wr_take;
            rd_ready <= rd_take;

            if (wr_fire) begin
                b_valid <= 1'b1;
                if (wr_hit && wr_index == '0) begin
                    // oversized lengths saturate
                    if (wr_merged > `NG_MAX_BURST) begin
                        cfg.burst_length <= burst_len_width'(`NG_MAX_BURST);
                    end else begin
                        cfg.burst_length <= wr_merged[burst_len_width-1:0];
                    end
                end else if (wr_hit) begin
                    cfg.dest_table[wr_entry[entry_width-1:0]] <=
                        wr_merged[`NG_DEST_WIDTH-1:0];
                end
            end else if (b_valid && axil_req.bready) begin
                b_valid <= 1'b0;
            end

            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_valid && axil_req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge clock) begin
        if (wr_fire) begin
            if (wr_hit) begin
                b_resp <= okay;
            end else begin
                b_resp <= slverr;
            end
        end
        if (rd_fire) begin
            r_data <= rd_word;
            if (rd_hit) begin
                r_resp <= okay;
            end else begin
                r_resp <= slverr;
            end
        end
    end

    always_comb begin
        axil_rsp.awready = wr_ready;
        axil_rsp.wready = wr_ready;
        axil_rsp.bvalid = b_valid;
        axil_rsp.bresp = b_resp;
        axil_rsp.arready = rd_ready;
        axil_rsp.rvalid = r_valid;
        axil_rsp.rdata = r_data;
        axil_rsp.rresp = r_resp;
    end

endmodule

`default_nettype wire

//--- verilog/prbs_lane.sv
`default_nettype none

`include "noise_gen_cfg.svh"

module prbs_lane #(
    parameter logic [`NG_LFSR_WIDTH-1:0] SEED = `NG_LFSR_WIDTH'(1)
) (
    input logic clock,
    input logic reset,
    input logic advance,
    output logic bit_out
);

    logic [`NG_LFSR_WIDTH-1:0] state;
    logic feedback;

    // x^21 + x^19 + 1
    assign feedback = state[`NG_TAP_HI] ^ state[`NG_TAP_LO];

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= SEED;
        end else if (advance) begin
            state <= {state[`NG_LFSR_WIDTH-2:0], feedback};
        end
    end

    // top bit is the lane's noise bit
    assign bit_out = state[`NG_LFSR_WIDTH-1];

endmodule

`default_nettype wire

//--- verilog/noise_burst_ctrl.sv
`default_nettype none

`include "noise_gen_cfg.svh"

module noise_burst_ctrl
    import noise_gen_pkg::*;
(
    input logic clock,
    input logic reset,
    input noise_cfg_t cfg,
    input logic trigger,
    input logic [`NG_LANES-1:0] lane_bits,
    output logic advance,
    output noise_sample_t sample,
    output logic sample_valid,
    input logic sample_ready
);

    burst_state_e state;
    logic [entry_width-1:0] count;
    logic [entry_width-1:0] next_count;
    logic [`NG_DEST_WIDTH-1:0] dest_q;
    logic last_q;
    logic transfer;
    logic start;

    assign transfer = sample_valid && sample_ready;
    assign start = (state == idle) && trigger && (cfg.burst_length != '0);
    assign next_count = count + 1'b1;

    // lanes move only when a beat leaves
    assign advance = transfer;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            count <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= working;
                        count <= '0;
                    end
                end
                working: begin
                    if (transfer) begin
                        if (last_q) begin
                            state <= idle;
                        end else begin
                            count <= next_count;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // tag and end marker for the beat on offer
    always_ff @(posedge clock) begin
        if (start) begin
            dest_q <= cfg.dest_table[0];
            last_q <= (cfg.burst_length == burst_len_width'(1));
        end else if (transfer && !last_q) begin
            dest_q <= cfg.dest_table[next_count];
            last_q <= (burst_len_width'(next_count) == cfg.burst_length - 1'b1);
        end
    end

    assign sample_valid = (state == working);

    // lane bits hold still until the transfer edge,
    // so the noise word is taken straight from the lanes
    always_comb begin
        sample.data = {{(sample_width - `NG_LANES){lane_bits[`NG_LANES-1]}}, lane_bits};
        sample.dest = dest_q;
        sample.last = last_q;
    end

endmodule

`default_nettype wire

//--- verilog/noise_generator.sv
`default_nettype none

`include "noise_gen_cfg.svh"

module noise_generator
    import noise_gen_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic trigger,
    output logic active,
    input axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output noise_sample_t sample,
    output logic sample_valid,
    input logic sample_ready
);

    noise_cfg_t cfg;
    logic advance;
    logic [`NG_LANES-1:0] lane_bits;

    noise_regs u_noise_regs (
        .clock(clock),
        .reset(reset),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .cfg(cfg)
    );

    // one bit per lane, lane i lands in bit i
    for (genvar i = 0; i < `NG_LANES; i++) begin : g_lane
        prbs_lane #(
            .SEED(lane_seeds[i])
        ) u_prbs_lane (
            .clock(clock),
            .reset(reset),
            .advance(advance),
            .bit_out(lane_bits[i])
        );
    end

    noise_burst_ctrl u_noise_burst_ctrl (
        .clock(clock),
        .reset(reset),
        .cfg(cfg),
        .trigger(trigger),
        .lane_bits(lane_bits),
        .advance(advance),
        .sample(sample),
        .sample_valid(sample_valid),
        .sample_ready(sample_ready)
    );

    // a nonzero length arms the generator
    assign active = (cfg.burst_length != '0);

endmodule

`default_nettype wire

//--- sim/noise_generator_tb.sv
`default_nettype none

`include "noise_gen_cfg.svh"

module noise_generator_tb
    import noise_gen_pkg::*;
();

    localparam int num_bursts = 12;
    localparam int reg_margin = 20000;
    localparam int timeout = num_bursts * `NG_MAX_BURST * 8 * 8 + reg_margin;
    localparam logic [`NG_ADDR_WIDTH-1:0] length_addr = '0;
    localparam logic [3:0][7:0] unmapped_addrs = {8'h44, 8'h06, 8'h81, 8'hfc};

    logic clock;
    logic reset;
    logic trigger;
    logic active;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    noise_sample_t sample;
    logic sample_valid;
    logic sample_ready;

    // reference copy of lanes and registers
    logic [`NG_LFSR_WIDTH-1:0] lane_state [`NG_LANES];
    logic [`NG_DEST_WIDTH-1:0] exp_dest [`NG_MAX_BURST];
    int exp_length = 0;
    int beats_allowed = 0;
    int beats_seen = 0;
    logic [31:0] rng_state = 32'h01a6_157e;

    noise_generator u_noise_generator (
        .clock(clock),
        .reset(reset),
        .trigger(trigger),
        .active(active),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .sample(sample),
        .sample_valid(sample_valid),
        .sample_ready(sample_ready)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        #(timeout);
        $display("watchdog: the run did not finish within %0d time units", timeout);
        $display("=== FAIL ===");
        $fatal(1, "run timed out");
    end

    // one right shift of a 32-bit galois register
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], rng_state[0]};
            rng_state = galois_step(rng_state);
        end
    endtask

    function automatic logic [`NG_ADDR_WIDTH-1:0] dest_addr(input int k);
        return `NG_ADDR_WIDTH'(4 * (k + 1));
    endfunction

    // expected beat k from the lane model and the register copy
    function automatic noise_sample_t expected_sample(input int k);
        noise_sample_t want;
        logic [`NG_LANES-1:0] bits;
        for (int i = 0; i < `NG_LANES; i++) begin
            bits[i] = lane_state[i][`NG_LFSR_WIDTH-1];
        end
        want.data = {{(32 - `NG_LANES){bits[`NG_LANES-1]}}, bits};
        want.dest = exp_dest[k];
        want.last = (k == exp_length - 1);
        return want;
    endfunction

    task automatic step_lanes();
        for (int i = 0; i < `NG_LANES; i++) begin
            lane_state[i] = {lane_state[i][`NG_LFSR_WIDTH-2:0],
                lane_state[i][`NG_TAP_HI] ^ lane_state[i][`NG_TAP_LO]};
        end
    endtask

    task automatic compare_sample(input string name, input noise_sample_t got,
        input noise_sample_t want);
        if (got !== want) begin
            $display("error %s: data 0x%h dest 0x%h last 0x%h, expected 0x%h 0x%h 0x%h",
                name, got.data, got.dest, got.last, want.data, want.dest, want.last);
            $display("=== FAIL ===");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic compare_resp(input string name, input axil_resp_e got, input axil_resp_e want);
        if (got !== want) begin
            $display("error %s: got 0x%h expected 0x%h", name, got, want);
            $display("=== FAIL ===");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
        input logic [31:0] want);
        if (got !== want) begin
            $display("error %s: got 0x%h expected 0x%h", name, got, want);
            $display("=== FAIL ===");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("error %s: got 0x%h expected 0x%h", name, got, want);
            $display("=== FAIL ===");
            $fatal(1, "bit mismatch");
        end
    endtask

    // full write handshake, then check the response code
    task automatic write_expect(input logic [`NG_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
        input logic [3:0] strb, input axil_resp_e want);
        @(negedge clock);
        axil_req.awvalid = 1'b1;
        axil_req.wvalid = 1'b1;
        axil_req.awaddr = addr;
        axil_req.wdata = data;
        axil_req.wstrb = strb;
        axil_req.bready = 1'b1;
        @(negedge clock);
        while (!axil_rsp.awready) @(negedge clock);
        compare_bit("wready", axil_rsp.wready, 1'b1);
        // accepted on the coming rising edge
        @(negedge clock);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        while (!axil_rsp.bvalid) @(negedge clock);
        compare_resp("bresp", axil_rsp.bresp, want);
        @(negedge clock);
        axil_req.bready = 1'b0;
    endtask

    task automatic read_expect(input logic [`NG_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
        input axil_resp_e want);
        @(negedge clock);
        axil_req.arvalid = 1'b1;
        axil_req.araddr = addr;
        axil_req.rready = 1'b1;
        @(negedge clock);
        while (!axil_rsp.arready) @(negedge clock);
        @(negedge clock);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) @(negedge clock);
        compare_resp("rresp", axil_rsp.rresp, want);
        compare_word("rdata", axil_rsp.rdata, data);
        @(negedge clock);
        axil_req.rready = 1'b0;
    endtask

    task automatic readback_all();
        for (int k = 0; k < `NG_MAX_BURST; k++) begin
            read_expect(dest_addr(k), 32'(exp_dest[k]), okay);
        end
        read_expect(length_addr, 32'(exp_length), okay);
    endtask

    task automatic test_registers();
        logic [31:0] r;
        draw_bits(4, r);
        exp_length = int'(r[3:0]) + 1;
        write_expect(length_addr, 32'(exp_length), 4'hf, okay);
        read_expect(length_addr, 32'(exp_length), okay);
        compare_bit("active", active, 1'b1);
        // oversized length saturates at the maximum
        write_expect(length_addr, 32'h0000_0105, 4'hf, okay);
        exp_length = `NG_MAX_BURST;
        read_expect(length_addr, 32'(exp_length), okay);
        for (int k = 0; k < `NG_MAX_BURST; k++) begin
            draw_bits(32, r);
            write_expect(dest_addr(k), r, 4'hf, okay);
            exp_dest[k] = r[`NG_DEST_WIDTH-1:0];
        end
        // strobes that miss the low byte leave the entry alone
        draw_bits(8, r);
        write_expect(dest_addr(5), {r[7:0], r[7:0], r[7:0], 8'h00}, 4'b1110, okay);
        write_expect(length_addr, 32'h0, 4'b0000, okay);
        readback_all();
    endtask

    task automatic test_unmapped();
        for (int i = 0; i < 4; i++) begin
            write_expect(unmapped_addrs[i], 32'hffff_ffff, 4'hf, slverr);
            read_expect(unmapped_addrs[i], 32'h0, slverr);
        end
        readback_all();
    endtask

    task automatic test_zero_length();
        write_expect(length_addr, 32'h0, 4'hf, okay);
        exp_length = 0;
        @(negedge clock);
        compare_bit("active", active, 1'b0);
        sample_ready = 1'b1;
        trigger = 1'b1;
        @(negedge clock);
        trigger = 1'b0;
        repeat (8) begin
            @(negedge clock);
            compare_bit("sample_valid", sample_valid, 1'b0);
            compare_bit("active", active, 1'b0);
        end
        sample_ready = 1'b0;
    endtask

    // new length and one new tag, then a triggered burst
    task automatic run_burst(input logic stall, input logic retrigger);
        logic [31:0] r;
        int entry;
        int cycles;
        draw_bits(4, r);
        exp_length = int'(r[3:0]) + 1;
        write_expect(length_addr, 32'(exp_length), 4'hf, okay);
        draw_bits(4, r);
        entry = int'(r[3:0]);
        draw_bits(8, r);
        write_expect(dest_addr(entry), r, 4'hf, okay);
        exp_dest[entry] = r[`NG_DEST_WIDTH-1:0];
        beats_allowed = beats_allowed + exp_length;
        cycles = 0;
        @(negedge clock);
        trigger = 1'b1;
        @(negedge clock);
        trigger = 1'b0;
        while (beats_seen < beats_allowed) begin
            if (stall) begin
                draw_bits(2, r);
                sample_ready = |r[1:0];
            end else begin
                sample_ready = 1'b1;
            end
            // extra triggers only land while the burst is still running
            if (retrigger) begin
                draw_bits(1, r);
                trigger = r[0];
            end
            cycles++;
            @(negedge clock);
        end
        trigger = 1'b0;
        sample_ready = 1'b0;
        compare_bit("sample_valid", sample_valid, 1'b0);
        if (!stall) begin
            compare_word("burst cycles", 32'(cycles), 32'(exp_length));
        end
        repeat (3) begin
            @(negedge clock);
            compare_bit("sample_valid", sample_valid, 1'b0);
        end
    endtask

    // monitor samples between the driving edge and the transfer edge
    initial begin : monitor
        noise_sample_t want;
        int beat_index;
        beat_index = 0;
        forever begin
            @(negedge clock);
            #2;
            if (reset && sample_valid && sample_ready) begin
                if (beats_seen >= beats_allowed) begin
                    $display("a stream beat was transferred while no burst beat was due");
                    $display("=== FAIL ===");
                    $fatal(1, "unexpected beat");
                end else begin
                    want = expected_sample(beat_index);
                    compare_sample("sample", sample, want);
                    step_lanes();
                    beats_seen++;
                    if (want.last) begin
                        beat_index = 0;
                    end else begin
                        beat_index++;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        reset = 1'b0;
        trigger = 1'b0;
        sample_ready = 1'b0;
        axil_req = '0;
        for (int i = 0; i < `NG_LANES; i++) begin
            lane_state[i] = lane_seeds[i];
        end
        for (int k = 0; k < `NG_MAX_BURST; k++) begin
            exp_dest[k] = '0;
        end
        repeat (4) @(negedge clock);
        reset = 1'b1;
        compare_bit("sample_valid", sample_valid, 1'b0);
        compare_bit("active", active, 1'b0);

        test_registers();
        test_unmapped();
        test_zero_length();
        // plain bursts, then stalls, then stalls with repeated triggers
        for (int b = 0; b < num_bursts; b++) begin
            run_burst(b >= num_bursts / 3, b >= 2 * num_bursts / 3);
        end

        @(negedge clock);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
verilog/noise_gen_pkg.sv
verilog/noise_regs.sv
verilog/prbs_lane.sv
verilog/noise_burst_ctrl.sv
verilog/noise_generator.sv
sim/noise_generator_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
verilator --binary --timing -f project.f --top-module noise_generator_tb -o noise_sim \
    && ./obj_dir/noise_sim | grep -F "=== PASS ===" \
    || { echo "simulation did not pass"; exit 1; }
